// ==== verilog.f ====
+incdir+.
azLspPkg.sv
coeffIf.sv
polyCoeffBuilder.sv
chebEval.sv
fracDivide.sv
rootSearch.sv
azToLsp.sv
azToLspTb.sv

// ==== azToLspTb.sv ====
`timescale 1ns/1ps
`include "azLsp_cfg.svh"

module azToLspTb;
	import azLspPkg::*;

	localparam int FRAMES = 8;
	localparam int FRAME_CYCLES = 2000; // Worst-case frame length
	localparam int ACK_HOLD_CYCLES = 1500; // Longer than a whole search
	localparam int LONG_HOLD_OUTPUT = 3;
	localparam int HALF_PERIOD = 20;
	localparam int WATCHDOG_NS = (FRAMES * FRAME_CYCLES + ACK_HOLD_CYCLES + 50) * 2 * HALF_PERIOD;
	localparam int TOLERANCE = 40;
	localparam real PI = 3.14159265358979;

	logic clk;
	logic reset;
	logic lpcReq;
	logic lpcAck;
	logic signed [`WORD_W-1:0] lpcCoeffs [`LPC_ORDER];
	logic lspReq;
	logic lspAck;
	logic signed [`WORD_W-1:0] lspWord [`LPC_ORDER];
	logic fallback;

	int kindQ [$]; // 0 zero filter, 1 large random
	int acceptCount;
	int outCount;
	bit pipelinedSeen;
	bit fallbackSeen;
	logic signed [`WORD_W-1:0] lastGood [`LPC_ORDER];
	logic signed [`WORD_W-1:0] seenWords [`LPC_ORDER];
	logic seenFallback;

	azToLsp dut
	(
		.clk(clk),
		.reset(reset),
		.lpcReq(lpcReq),
		.lpcAck(lpcAck),
		.lpcCoeffs(lpcCoeffs),
		.lspReq(lspReq),
		.lspAck(lspAck),
		.lspWord(lspWord),
		.fallback(fallback)
	);

	always #(HALF_PERIOD) clk = ~clk;

	task automatic stopWithFailure(input string why);
		$display("%s", why);
		$display("Errors found");
		$fatal(1, "Run stopped");
	endtask

	function automatic string mismatchText(input string name, input int expected, input int actual);
		return $sformatf("Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
	endfunction

	task automatic nextCycle();
		@(posedge clk);
		#2;
	endtask

	////////////////////
	// Handshake rules
	lpcAckAfterReq: assert property (@(posedge clk) disable iff (reset)
		$rose(lpcAck) |-> $past(lpcReq))
		else stopWithFailure("lpcAck rose while lpcReq was low");
	lpcAckDropAfterReq: assert property (@(posedge clk) disable iff (reset)
		$fell(lpcAck) |-> !$past(lpcReq))
		else stopWithFailure("lpcAck fell while lpcReq was still high");
	lspReqHeld: assert property (@(posedge clk) disable iff (reset)
		lspReq && !lspAck |=> lspReq)
		else stopWithFailure("lspReq fell before lspAck rose");
	lspReqAfterAckLow: assert property (@(posedge clk) disable iff (reset)
		$rose(lspReq) |-> !$past(lspAck))
		else stopWithFailure("lspReq rose while lspAck was still high");
	fallbackStable: assert property (@(posedge clk) disable iff (reset)
		lspReq && $past(lspReq) |-> $stable(fallback))
		else stopWithFailure("fallback changed while lspReq was high");

	task automatic sendFrame(input int kind);
		int mag;
		int holdCycles;
		for (int k = 0; k < `LPC_ORDER; k++)
		begin
			if (kind == 0)
				lpcCoeffs[k] = '0;
			else
			begin
				mag = 12288 + $urandom_range(0, 20479);
				lpcCoeffs[k] = $urandom_range(0, 1) ? -mag : mag;
			end
		end
		lpcReq = 1'b1;
		do
			nextCycle();
		while (!lpcAck);
		if (acceptCount > outCount)
			pipelinedSeen = 1'b1; // Earlier frame still waiting for its output
		kindQ.push_back(kind);
		acceptCount++;
		holdCycles = $urandom_range(0, 3); // lpcAck must stay up meanwhile
		repeat (holdCycles) nextCycle();
		lpcReq = 1'b0;
		do
			nextCycle();
		while (lpcAck);
	endtask

	task automatic checkFrame();
		int kind;
		int expected;
		assert (kindQ.size() > 0)
			else stopWithFailure("An output arrived with no frame outstanding");
		kind = kindQ.pop_front();
		if (kind == 0)
		begin
			assert (seenFallback == 1'b0)
				else stopWithFailure(mismatchText("fallback", 0, seenFallback));
			// Roots of 1 +/- z^-11
			for (int k = 0; k < `LPC_ORDER; k++)
			begin
				expected = $rtoi(32768.0 * $cos((k + 1) * PI / 11.0));
				assert (seenWords[k] - expected <= TOLERANCE && expected - seenWords[k] <= TOLERANCE)
					else stopWithFailure(mismatchText($sformatf("lspWord[%0d]", k), expected,
						seenWords[k]));
			end
		end
		if (seenFallback)
		begin
			fallbackSeen = 1'b1;
			for (int k = 0; k < `LPC_ORDER; k++)
				assert (seenWords[k] == lastGood[k])
					else stopWithFailure(mismatchText($sformatf("lspWord[%0d]", k), lastGood[k],
						seenWords[k]));
		end
		else
		begin
			for (int k = 0; k < `LPC_ORDER; k++)
				assert (seenWords[k] <= gridTable[0] && seenWords[k] >= gridTable[`GRID_POINTS])
					else stopWithFailure($sformatf("lspWord[%0d] = %0d lies outside the grid",
						k, seenWords[k]));
			for (int k = 1; k < `LPC_ORDER; k++)
				assert (seenWords[k] < seenWords[k-1])
					else stopWithFailure($sformatf("lspWord[%0d] = %0d is not below lspWord[%0d] = %0d",
						k, seenWords[k], k - 1, seenWords[k-1]));
			lastGood = seenWords;
		end
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		lpcReq = 1'b0;
		lspAck = 1'b0;
		for (int k = 0; k < `LPC_ORDER; k++)
			lpcCoeffs[k] = '0;
		lastGood = lspInit;
		acceptCount = 0;
		outCount = 0;
		pipelinedSeen = 1'b0;
		fallbackSeen = 1'b0;
		void'($urandom(32'hf5ff));
		repeat (5) @(posedge clk);
		#2;
		reset = 1'b0;
		assert (!lpcAck && !lspReq && !fallback && !dut.link.req && !dut.link.ack)
			else stopWithFailure("Handshake outputs were not low after reset");

		// Random frame first, so a fallback meets lspInit
		for (int f = 0; f < FRAMES; f++)
			sendFrame((f == 1 || f == 5) ? 0 : 1);
		while (outCount < FRAMES)
			nextCycle();
		repeat (50) nextCycle(); // Room for a stray output

		if (outCount == FRAMES && acceptCount == FRAMES && kindQ.size() == 0 && !lspReq
			&& pipelinedSeen && fallbackSeen)
		begin
			$display("No errors");
			$finish;
		end
		else
		begin
			if (outCount != FRAMES || lspReq)
				$display("%s", mismatchText("output count", FRAMES, outCount));
			if (!pipelinedSeen)
				$display("No frame was accepted while an earlier output was pending");
			if (!fallbackSeen)
				$display("No frame ended in fallback");
			stopWithFailure("End-of-run checks did not hold");
		end
	end

	////////////////////
	// Output side with random back-pressure
	initial
	begin : outputSide
		int waitCycles;
		int ackHold;
		wait (reset === 1'b0);
		forever
		begin
			nextCycle();
			if (lspReq)
			begin
				seenWords = lspWord;
				seenFallback = fallback;
				waitCycles = $urandom_range(0, 8);
				repeat (waitCycles) nextCycle();
				for (int k = 0; k < `LPC_ORDER; k++)
					assert (lspWord[k] == seenWords[k])
						else stopWithFailure(mismatchText($sformatf("held lspWord[%0d]", k),
							seenWords[k], lspWord[k]));
				checkFrame();
				lspAck = 1'b1;
				do
					nextCycle();
				while (lspReq);
				// One long hold lets the next frame's search finish under a high lspAck
				ackHold = (outCount == LONG_HOLD_OUTPUT) ? ACK_HOLD_CYCLES : $urandom_range(0, 3);
				repeat (ackHold) nextCycle();
				lspAck = 1'b0;
				outCount++;
			end
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		stopWithFailure("Timeout before all frames were delivered");
	end

endmodule

// ==== azToLsp.sv ====
`timescale 1ns/1ps
`include "azLsp_cfg.svh"

module azToLsp
(
	input logic clk,
	input logic reset,
	input logic lpcReq,
	output logic lpcAck,
	input logic signed [`WORD_W-1:0] lpcCoeffs [`LPC_ORDER],
	output logic lspReq,
	input logic lspAck,
	output logic signed [`WORD_W-1:0] lspWord [`LPC_ORDER],
	output logic fallback
);

	// F1/F2 hand-off between the stages
	coeffIf link (.clk(clk));

	polyCoeffBuilder builder
	(
		.clk(clk),
		.reset(reset),
		.lpcReq(lpcReq),
		.lpcAck(lpcAck),
		.lpcCoeffs(lpcCoeffs),
		.out(link.builder)
	);

	rootSearch search
	(
		.clk(clk),
		.reset(reset),
		.in(link.search),
		.lspReq(lspReq),
		.lspAck(lspAck),
		.lspWord(lspWord),
		.fallback(fallback)
	);

endmodule

// ==== rootSearch.sv ====
`timescale 1ns/1ps
`include "azLsp_cfg.svh"

module rootSearch
(
	input logic clk,
	input logic reset,
	coeffIf.search in,
	output logic lspReq,
	input logic lspAck,
	output logic signed [`WORD_W-1:0] lspWord [`LPC_ORDER],
	output logic fallback
);
	import azLspPkg::*;

	localparam logic [3:0] S_IDLE = 4'd0;
	localparam logic [3:0] S_ACK = 4'd1;
	localparam logic [3:0] S_LOW_START = 4'd2;
	localparam logic [3:0] S_LOW_EVAL = 4'd3;
	localparam logic [3:0] S_STEP = 4'd4;
	localparam logic [3:0] S_GRID_EVAL = 4'd5;
	localparam logic [3:0] S_BISECT = 4'd6;
	localparam logic [3:0] S_MID_EVAL = 4'd7;
	localparam logic [3:0] S_INTERP = 4'd8;
	localparam logic [3:0] S_DIVIDE = 4'd9;
	localparam logic [3:0] S_STORE = 4'd10;
	localparam logic [3:0] S_FINISH = 4'd11;
	localparam logic [3:0] S_OUT = 4'd12;
	localparam logic [3:0] S_OUT_DONE = 4'd13;

	logic [3:0] state;
	logic [5:0] gridIdx;
	logic [3:0] rootCount;
	logic [2:0] bisectCount;
	logic ipSel;

	logic signed [`WORD_W-1:0] f1Reg [`HALF_ORDER];
	logic signed [`WORD_W-1:0] f2Reg [`HALF_ORDER];
	logic signed [`WORD_W-1:0] lspNew [`LPC_ORDER];
	logic signed [`WORD_W-1:0] lspOld [`LPC_ORDER];
	logic signed [`WORD_W-1:0] xLow, xHigh, xMid, yLow, yHigh, xInt;
	logic signed [`WORD_W-1:0] xDiff;
	logic ySign;
	logic [3:0] normExp;

	logic chebStart, chebDone;
	logic signed [`WORD_W-1:0] chebX, chebValue;
	logic signed [`WORD_W-1:0] chebCoeffs [`HALF_ORDER];
	logic divStart, divDone;
	logic [`WORD_W-1:0] divDen, divQuot;

	logic signed [`WORD_W:0] yDiff, yAbsWide;
	logic [`WORD_W-1:0] yAbs;
	logic signed [`ACC_W-1:0] stepProd, lowProd;
	logic signed [`WORD_W-1:0] yStep, interpX;
	logic signChange, midChange;

	function automatic logic [3:0] normShift(input logic [`WORD_W-1:0] v);
		logic [3:0] n;
		logic found;
		n = '0;
		found = 1'b0;
		for (int i = `WORD_W-2; i >= 0; i--)
		begin
			if (!found)
			begin
				if (v[i])
					found = 1'b1;
				else
					n = n + 4'd1;
			end
		end
		return n;
	endfunction

	always_comb
	begin
		for (int k = 0; k < `HALF_ORDER; k++)
			chebCoeffs[k] = ipSel ? f2Reg[k] : f1Reg[k];
	end

	// Product <= 0 means a root in between
	assign signChange = (chebValue == '0) || (yHigh == '0)
		|| (chebValue[`WORD_W-1] != yHigh[`WORD_W-1]);
	assign midChange = (chebValue == '0) || (yLow == '0)
		|| (chebValue[`WORD_W-1] != yLow[`WORD_W-1]);

	assign yDiff = yHigh - yLow;
	assign yAbsWide = yDiff[`WORD_W] ? -yDiff : yDiff;
	assign yAbs = (yAbsWide > 17'sd32767) ? 16'h7fff : yAbsWide[`WORD_W-1:0];

	////////////////////
	// Interpolation from divider result
	always_comb
	begin
		stepProd = (xDiff * $signed({1'b0, divQuot[`WORD_W-2:0]})) <<< 1;
		stepProd = stepProd >>> (`INTERP_SHIFT - normExp);
		yStep = ySign ? -stepProd[`WORD_W-1:0] : stepProd[`WORD_W-1:0];
		lowProd = (yLow * yStep) <<< 1;
		lowProd = lowProd >>> `YLOW_SHIFT;
		interpX = xLow - lowProd[`WORD_W-1:0];
	end

	chebEval cheb
	(
		.clk(clk),
		.reset(reset),
		.start(chebStart),
		.coeffs(chebCoeffs),
		.x(chebX),
		.done(chebDone),
		.value(chebValue)
	);

	fracDivide div
	(
		.clk(clk),
		.reset(reset),
		.start(divStart),
		.num(`DIV_NUM),
		.den(divDen),
		.done(divDone),
		.quot(divQuot)
	);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= S_IDLE;
			in.ack <= 1'b0;
			lspReq <= 1'b0;
			fallback <= 1'b0;
			chebStart <= 1'b0;
			divStart <= 1'b0;
			rootCount <= '0;
			gridIdx <= '0;
			bisectCount <= '0;
			ipSel <= 1'b0;
			lspOld <= lspInit;
		end
		else
		begin
			chebStart <= 1'b0;
			divStart <= 1'b0;
			case (state)
				S_IDLE:
					if (in.req)
					begin
						f1Reg <= in.f1;
						f2Reg <= in.f2;
						in.ack <= 1'b1;
						state <= S_ACK;
					end
				S_ACK:
					if (!in.req)
					begin
						in.ack <= 1'b0;
						rootCount <= '0;
						gridIdx <= '0;
						ipSel <= 1'b0;
						xLow <= gridTable[0];
						state <= S_LOW_START;
					end
				S_LOW_START:
				begin
					chebX <= xLow;
					chebStart <= 1'b1;
					state <= S_LOW_EVAL;
				end
				S_LOW_EVAL:
					if (chebDone)
					begin
						yLow <= chebValue;
						state <= S_STEP;
					end
				S_STEP:
					if (rootCount == `LPC_ORDER || gridIdx == `GRID_POINTS)
						state <= S_FINISH;
					else
					begin
						gridIdx <= gridIdx + 6'd1;
						xHigh <= xLow;
						yHigh <= yLow;
						xLow <= gridTable[gridIdx+1];
						chebX <= gridTable[gridIdx+1];
						chebStart <= 1'b1;
						state <= S_GRID_EVAL;
					end
				S_GRID_EVAL:
					if (chebDone)
					begin
						yLow <= chebValue;
						bisectCount <= '0;
						state <= signChange ? S_BISECT : S_STEP;
					end
				S_BISECT:
					if (bisectCount == `BISECT_STEPS)
						state <= S_INTERP;
					else
					begin
						xMid <= (xLow >>> 1) + (xHigh >>> 1);
						chebX <= (xLow >>> 1) + (xHigh >>> 1);
						chebStart <= 1'b1;
						state <= S_MID_EVAL;
					end
				S_MID_EVAL:
					if (chebDone)
					begin
						if (midChange)
						begin
							xHigh <= xMid;
							yHigh <= chebValue;
						end
						else
						begin
							xLow <= xMid;
							yLow <= chebValue;
						end
						bisectCount <= bisectCount + 3'd1;
						state <= S_BISECT;
					end
				S_INTERP:
				begin
					xDiff <= xHigh - xLow;
					ySign <= yDiff[`WORD_W];
					normExp <= normShift(yAbs);
					divDen <= yAbs << normShift(yAbs);
					if (yDiff == '0)
					begin
						xInt <= xLow; // Flat segment
						state <= S_STORE;
					end
					else
					begin
						divStart <= 1'b1;
						state <= S_DIVIDE;
					end
				end
				S_DIVIDE:
					if (divDone)
					begin
						xInt <= interpX;
						state <= S_STORE;
					end
				S_STORE:
				begin
					lspNew[rootCount] <= xInt;
					xLow <= xInt;
					rootCount <= rootCount + 4'd1;
					ipSel <= !ipSel; // F1 and F2 roots interlace
					state <= S_LOW_START;
				end
				S_FINISH:
				begin
					if (rootCount == `LPC_ORDER)
					begin
						lspWord <= lspNew;
						lspOld <= lspNew;
						fallback <= 1'b0;
					end
					else
					begin
						lspWord <= lspOld;
						fallback <= 1'b1;
					end
					lspReq <= 1'b1;
					state <= S_OUT;
				end
				S_OUT:
					if (lspAck)
					begin
						lspReq <= 1'b0;
						state <= S_OUT_DONE;
					end
				default:
					if (!lspAck)
						state <= S_IDLE;
			endcase
		end
	end

	rootLimit: assert property (@(posedge in.clk) disable iff (reset)
		state == S_STORE |-> rootCount < `LPC_ORDER);

endmodule

// ==== fracDivide.sv ====
`timescale 1ns/1ps
`include "azLsp_cfg.svh"

module fracDivide
(
	input logic clk,
	input logic reset,
	input logic start,
	input logic [`WORD_W-1:0] num,
	input logic [`WORD_W-1:0] den,
	output logic done,
	output logic [`WORD_W-1:0] quot
);

	logic busy;
	logic [4:0] step;
	logic [`WORD_W:0] rem, remShift;
	logic [`WORD_W-1:0] denReg;
	logic [`WORD_W-2:0] q;

	assign remShift = rem << 1;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			done <= 1'b0;
			step <= '0;
		end
		else
		begin
			done <= 1'b0;
			if (start)
			begin
				busy <= 1'b1;
				step <= '0;
			end
			else if (busy)
			begin
				step <= step + 5'd1;
				if (step == 5'd16)
				begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (start)
		begin
			rem <= {1'b0, num};
			denReg <= den;
			q <= '0;
		end
		else if (busy && step < 5'd15)
		begin
			// One quotient bit per cycle
			if (remShift >= {1'b0, denReg})
			begin
				rem <= remShift - {1'b0, denReg};
				q <= {q[`WORD_W-3:0], 1'b1};
			end
			else
			begin
				rem <= remShift;
				q <= {q[`WORD_W-3:0], 1'b0};
			end
		end
		else if (busy && step == 5'd15)
			quot <= {1'b0, q};
	end

	denNonZero: assert property (@(posedge clk) disable iff (reset)
		start |-> den != '0 && num <= den);

endmodule

// ==== chebEval.sv ====
`timescale 1ns/1ps
`include "azLsp_cfg.svh"

module chebEval
(
	input logic clk,
	input logic reset,
	input logic start,
	input logic signed [`WORD_W-1:0] coeffs [`HALF_ORDER],
	input logic signed [`WORD_W-1:0] x,
	output logic done,
	output logic signed [`WORD_W-1:0] value
);
	import azLspPkg::*;

	logic busy;
	logic [2:0] step;
	logic signed [`WORD_W-1:0] cReg [`HALF_ORDER];
	logic signed [`WORD_W-1:0] xReg;
	logic signed [`WORD_W-1:0] b1, b2;
	logic signed [`WORD_W-1:0] bNext, finalVal;

	// b_k = 2x*b_{k+1} - b_{k+2} + f_k
	always_comb
	begin
		bNext = '0;
		if (step < 3'd5)
			bNext = satAdd(satMac(satMac(cReg[step], xReg, b1), xReg, b1), negSat(b2));
	end

	// Last term only half weight
	assign finalVal = satMac(satAdd(cReg[`HALF_ORDER-1] >>> 1, negSat(b2)), xReg, b1);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			done <= 1'b0;
			step <= '0;
		end
		else
		begin
			done <= 1'b0;
			if (start)
			begin
				busy <= 1'b1;
				step <= '0;
			end
			else if (busy)
			begin
				step <= step + 3'd1;
				if (step == 3'd6)
				begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (start)
		begin
			cReg <= coeffs;
			xReg <= x;
			b1 <= '0;
			b2 <= '0;
		end
		else if (busy)
		begin
			if (step < 3'd5)
			begin
				b1 <= bNext;
				b2 <= b1;
			end
			else if (step == 3'd5)
				value <= finalVal;
		end
	end

	noRestart: assert property (@(posedge clk) disable iff (reset)
		start |-> !busy);

endmodule

// ==== polyCoeffBuilder.sv ====
`timescale 1ns/1ps
`include "azLsp_cfg.svh"

module polyCoeffBuilder
(
	input logic clk,
	input logic reset,
	input logic lpcReq,
	output logic lpcAck,
	input logic signed [`WORD_W-1:0] lpcCoeffs [`LPC_ORDER],
	coeffIf.builder out
);
	import azLspPkg::*;

	localparam logic [1:0] B_IDLE = 2'd0;
	localparam logic [1:0] B_CALC = 2'd1;
	localparam logic [1:0] B_HOLD = 2'd2;
	localparam logic [1:0] B_WAIT = 2'd3;

	logic [1:0] state;
	logic [2:0] idx;
	logic signed [`WORD_W-1:0] aReg [`LPC_ORDER];
	logic signed [`WORD_W:0] pairSum, pairDiff;
	logic capture;

	assign capture = (state == B_IDLE) && lpcReq && !lpcAck;

	// a[idx+1] and a[10-idx], halved to Q11
	assign pairSum = aReg[idx] + aReg[`LPC_ORDER-1-idx];
	assign pairDiff = aReg[idx] - aReg[`LPC_ORDER-1-idx];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= B_IDLE;
			idx <= '0;
			lpcAck <= 1'b0;
			out.req <= 1'b0;
		end
		else
		begin
			if (capture)
				lpcAck <= 1'b1;
			else if (!lpcReq)
				lpcAck <= 1'b0;

			case (state)
				B_IDLE:
					if (capture)
					begin
						idx <= '0;
						state <= B_CALC;
					end
				B_CALC:
				begin
					idx <= idx + 3'd1;
					if (idx == 3'd4)
					begin
						out.req <= 1'b1;
						state <= B_HOLD;
					end
				end
				B_HOLD:
					if (out.ack)
					begin
						out.req <= 1'b0;
						state <= B_WAIT;
					end
				default:
					if (!out.ack)
						state <= B_IDLE; // Back-pressure released
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (capture)
		begin
			aReg <= lpcCoeffs;
			out.f1[0] <= `F_ONE;
			out.f2[0] <= `F_ONE;
		end
		else if (state == B_CALC)
		begin
			out.f1[idx+1] <= satAdd(pairSum[`WORD_W:1], negSat(out.f1[idx]));
			out.f2[idx+1] <= satAdd(pairDiff[`WORD_W:1], out.f2[idx]);
		end
	end

	reqHeld: assert property (@(posedge out.clk) disable iff (reset)
		out.req && !out.ack |=> out.req);

endmodule

// ==== coeffIf.sv ====
`timescale 1ns/1ps
`include "azLsp_cfg.svh"

interface coeffIf (input logic clk);

	logic signed [`WORD_W-1:0] f1 [`HALF_ORDER];
	logic signed [`WORD_W-1:0] f2 [`HALF_ORDER];
	logic req;
	logic ack;

	modport builder
	(
		input clk,
		input ack,
		output f1,
		output f2,
		output req
	);

	modport search
	(
		input clk,
		input f1,
		input f2,
		input req,
		output ack
	);

endinterface

// ==== azLspPkg.sv ====
package azLspPkg;

`include "azLsp_cfg.svh"

	////////////////////
	// Tables

	// Cosine grid, Q15, falling
	localparam logic signed [`WORD_W-1:0] gridTable [0:`GRID_POINTS] = '{
		32760, 32723, 32588, 32364, 32051, 31651,
		31164, 30591, 29935, 29196, 28377, 27481,
		26509, 25465, 24351, 23170, 21926, 20621,
		19260, 17846, 16384, 14876, 13327, 11743,
		10125, 8480, 6812, 5126, 3425, 1714,
		0, -1714, -3425, -5126, -6812, -8480,
		-10125, -11743, -13327, -14876, -16384, -17846,
		-19260, -20621, -21926, -23170, -24351, -25465,
		-26509, -27481, -28377, -29196, -29935, -30591,
		-31164, -31651, -32051, -32364, -32588, -32723,
		-32760
	};

	// LSPs taken as previous frame after reset
	localparam logic signed [`WORD_W-1:0] lspInit [0:`LPC_ORDER-1] = '{
		30000, 26000, 21000, 15000, 8000, 0, -8000, -15000, -21000, -26000
	};

	////////////////////
	// Saturating Q15 arithmetic
	//
	// F1 and F2 in Q11, with a[] in Q12:
	//   F1[0] = F2[0] = 1.0
	//   F1[i+1] = a[i+1] + a[10-i] - F1[i]
	//   F2[i+1] = a[i+1] - a[10-i] + F2[i]

	function automatic logic signed [`WORD_W-1:0] satAdd(
		input logic signed [`WORD_W-1:0] a,
		input logic signed [`WORD_W-1:0] b);
		logic signed [`WORD_W:0] sum;
		sum = a + b;
		if (sum > 17'sd32767)
			return 16'sh7fff;
		else if (sum < -17'sd32768)
			return 16'sh8000;
		return sum[`WORD_W-1:0];
	endfunction

	function automatic logic signed [`WORD_W-1:0] negSat(
		input logic signed [`WORD_W-1:0] a);
		if (a == 16'sh8000)
			return 16'sh7fff;
		return -a;
	endfunction

	function automatic logic signed [`WORD_W-1:0] multQ15(
		input logic signed [`WORD_W-1:0] a,
		input logic signed [`WORD_W-1:0] b);
		logic signed [`ACC_W-1:0] prod;
		prod = a * b;
		prod = prod >>> 15;
		if (prod > 32'sd32767)
			return 16'sh7fff; // only -1 * -1
		return prod[`WORD_W-1:0];
	endfunction

	function automatic logic signed [`WORD_W-1:0] satMac(
		input logic signed [`WORD_W-1:0] acc,
		input logic signed [`WORD_W-1:0] a,
		input logic signed [`WORD_W-1:0] b);
		return satAdd(acc, multQ15(a, b));
	endfunction

endpackage

// ==== azLsp_cfg.svh ====
`ifndef AZLSP_CFG_SVH
`define AZLSP_CFG_SVH

// Frame shape
`define LPC_ORDER 10
`define HALF_ORDER 6

`define WORD_W 16
`define ACC_W 32

// Root search
`define GRID_POINTS 60
`define BISECT_STEPS 4

// Q constants
`define F_ONE 16'sd2048 // 1.0 in Q11
`define DIV_NUM 16'd16383 // 0.5 in Q15
`define INTERP_SHIFT 20
`define YLOW_SHIFT 11

`endif
